// ==== design/flag_rf_pkg.sv ====
// widths, entry types and sweep state encoding for the flag register file
`default_nettype none

package flag_rf_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // condition flags held per physical register
  localparam int FLAG_WIDTH = 6;

  // flags plus the pending bit on top
  localparam int ENTRY_WIDTH = FLAG_WIDTH + 1;

  // default physical register count, power of two
  localparam int DEFAULT_REG_COUNT = 64;

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef logic [FLAG_WIDTH-1:0] flags_t;

  // bit ENTRY_WIDTH-1 is pending, all ones means allocated and not yet written
  typedef logic [ENTRY_WIDTH-1:0] entry_t;

  // write stage FSM
  typedef enum logic
  {
    SWEEP_CLEAR,
    SWEEP_RUN
  } sweep_state_t;

endpackage

`default_nettype wire

// ==== design/flag_write_stage.sv ====
// reset clearing sweep FSM and gating of external writes onto the bank write ports
`timescale 1ns/1ns
`default_nettype none

module flag_write_stage #(
  parameter int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT,
  parameter int ADDR_WIDTH = $clog2(REG_COUNT)
) (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          write0_en,
  input  wire [ADDR_WIDTH-1:0]         write0_addr,
  input  wire flag_rf_pkg::flags_t     write0_flags,

  input  wire                          write1_en,
  input  wire [ADDR_WIDTH-1:0]         write1_addr,
  input  wire flag_rf_pkg::flags_t     write1_flags,

  input  wire                          write2_en,
  input  wire [ADDR_WIDTH-1:0]         write2_addr,
  input  wire flag_rf_pkg::flags_t     write2_flags,

  input  wire                          alloc_en,
  input  wire [ADDR_WIDTH-1:0]         alloc_addr,

  output logic [2:0]                   bank_wen,
  output logic [ADDR_WIDTH-1:0]        bank_waddr0,
  output logic [ADDR_WIDTH-1:0]        bank_waddr1,
  output logic [ADDR_WIDTH-1:0]        bank_waddr2,
  output flag_rf_pkg::entry_t          bank_wdata0,
  output flag_rf_pkg::entry_t          bank_wdata1,
  output flag_rf_pkg::entry_t          bank_wdata2,
  output logic                         bank_alloc_en,
  output logic [ADDR_WIDTH-1:0]        bank_alloc_addr,

  output logic                         sweep_busy
);

  flag_rf_pkg::sweep_state_t state;
  flag_rf_pkg::sweep_state_t state_next;

  logic [ADDR_WIDTH-1:0] clear_addr;
  logic                  clear_last;

  // ----------------------------------------
  // sweep FSM
  // ----------------------------------------

  // REG_COUNT is a power of two, so the last entry is the all ones address
  assign clear_last = &clear_addr;

  always_comb
  begin
    state_next = state;
    case (state)
      flag_rf_pkg::SWEEP_CLEAR:
      begin
        if (clear_last)
          state_next = flag_rf_pkg::SWEEP_RUN;
      end
      default:
      begin
        state_next = flag_rf_pkg::SWEEP_RUN;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= flag_rf_pkg::SWEEP_CLEAR;
      clear_addr <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == flag_rf_pkg::SWEEP_CLEAR)
        clear_addr <= clear_addr + 1'b1;
    end
  end

  assign sweep_busy = (state == flag_rf_pkg::SWEEP_CLEAR);

  // ----------------------------------------
  // bank write ports
  // ----------------------------------------

  // port 0 is shared with the sweep, external traffic is dropped meanwhile
  always_comb
  begin
    if (sweep_busy)
    begin
      bank_wen      = 3'b001;
      bank_waddr0   = clear_addr;
      bank_wdata0   = '0;
      bank_alloc_en = 1'b0;
    end
    else
    begin
      bank_wen      = {write2_en, write1_en, write0_en};
      bank_waddr0   = write0_addr;
      bank_wdata0   = {1'b0, write0_flags};
      bank_alloc_en = alloc_en;
    end
  end

  // a completed write always clears pending
  assign bank_waddr1     = write1_addr;
  assign bank_wdata1     = {1'b0, write1_flags};
  assign bank_waddr2     = write2_addr;
  assign bank_wdata2     = {1'b0, write2_flags};
  assign bank_alloc_addr = alloc_addr;

endmodule

`default_nettype wire

// ==== design/flag_bank.sv ====
// flag entry storage with prioritized writes, held read port and retire read port
`timescale 1ns/1ns
`default_nettype none

module flag_bank #(
  parameter int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT,
  parameter int ADDR_WIDTH = $clog2(REG_COUNT)
) (
  input  wire                          clk,
  input  wire                          rst,

  input  wire [2:0]                    bank_wen,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr0,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr1,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr2,
  input  wire flag_rf_pkg::entry_t     bank_wdata0,
  input  wire flag_rf_pkg::entry_t     bank_wdata1,
  input  wire flag_rf_pkg::entry_t     bank_wdata2,
  input  wire                          bank_alloc_en,
  input  wire [ADDR_WIDTH-1:0]         bank_alloc_addr,

  input  wire [ADDR_WIDTH-1:0]         held_addr,
  output flag_rf_pkg::entry_t          held_entry,

  input  wire                          retire_en,
  input  wire [ADDR_WIDTH-1:0]         retire_addr,
  output flag_rf_pkg::flags_t          retire_flags
);

  flag_rf_pkg::entry_t mem [REG_COUNT];

  logic [ADDR_WIDTH-1:0] retire_addr_q;
  flag_rf_pkg::entry_t   retire_entry;

  // ----------------------------------------
  // storage update
  // ----------------------------------------

  // later assignments win on a shared address:
  // write2 over write1 over write0, allocate over all writes
  always_ff @(posedge clk)
  begin
    if (bank_wen[0])
      mem[bank_waddr0] <= bank_wdata0;
    if (bank_wen[1])
      mem[bank_waddr1] <= bank_wdata1;
    if (bank_wen[2])
      mem[bank_waddr2] <= bank_wdata2;
    if (bank_alloc_en)
      mem[bank_alloc_addr] <= '1;
  end

  // ----------------------------------------
  // read ports
  // ----------------------------------------

  // held address is registered in the bypass, so this is the stored value
  assign held_entry = mem[held_addr];

  // address captured at the strobe edge, data read after that edge's writes
  always_ff @(posedge clk)
  begin
    if (rst)
      retire_addr_q <= '0;
    else if (retire_en)
      retire_addr_q <= retire_addr;
  end

  assign retire_entry = mem[retire_addr_q];

  // retirement only needs the flags
  assign retire_flags = retire_entry[flag_rf_pkg::FLAG_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== design/flag_read_bypass.sv ====
// read address hold, read valid timing and forwarding of same-cycle bank writes
`timescale 1ns/1ns
`default_nettype none

module flag_read_bypass #(
  parameter int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT,
  parameter int ADDR_WIDTH = $clog2(REG_COUNT)
) (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          read_en,
  input  wire [ADDR_WIDTH-1:0]         read_addr,

  output logic [ADDR_WIDTH-1:0]        held_addr,
  input  wire flag_rf_pkg::entry_t     held_entry,

  input  wire [2:0]                    bank_wen,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr0,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr1,
  input  wire [ADDR_WIDTH-1:0]         bank_waddr2,
  input  wire flag_rf_pkg::entry_t     bank_wdata0,
  input  wire flag_rf_pkg::entry_t     bank_wdata1,
  input  wire flag_rf_pkg::entry_t     bank_wdata2,
  input  wire                          bank_alloc_en,
  input  wire [ADDR_WIDTH-1:0]         bank_alloc_addr,

  output flag_rf_pkg::entry_t          read_data,
  output logic                         read_valid,
  output logic                         read_forward
);

  // set by the first read strobe, keeps read_data at zero until then
  logic read_seen;

  logic                fwd_hit;
  flag_rf_pkg::entry_t fwd_entry;

  // ----------------------------------------
  // read strobe
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      held_addr  <= '0;
      read_valid <= 1'b0;
      read_seen  <= 1'b0;
    end
    else
    begin
      read_valid <= read_en;
      if (read_en)
      begin
        held_addr <= read_addr;
        read_seen <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // forwarding
  // ----------------------------------------

  // checked in the bank's store order so the last match is the value it keeps
  always_comb
  begin
    fwd_entry = held_entry;
    fwd_hit   = 1'b0;
    if (bank_wen[0] && (bank_waddr0 == held_addr))
    begin
      fwd_entry = bank_wdata0;
      fwd_hit   = 1'b1;
    end
    if (bank_wen[1] && (bank_waddr1 == held_addr))
    begin
      fwd_entry = bank_wdata1;
      fwd_hit   = 1'b1;
    end
    if (bank_wen[2] && (bank_waddr2 == held_addr))
    begin
      fwd_entry = bank_wdata2;
      fwd_hit   = 1'b1;
    end
    if (bank_alloc_en && (bank_alloc_addr == held_addr))
    begin
      fwd_entry = '1;
      fwd_hit   = 1'b1;
    end
  end

  assign read_data    = read_seen ? fwd_entry : '0;
  assign read_forward = read_seen & fwd_hit;

endmodule

`default_nettype wire

// ==== design/flag_regfile.sv ====
// flag register file top: write stage, entry bank and read bypass
`timescale 1ns/1ns
`default_nettype none

module flag_regfile #(
  parameter int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT,
  parameter int ADDR_WIDTH = $clog2(REG_COUNT)
) (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          write0_en,
  input  wire [ADDR_WIDTH-1:0]         write0_addr,
  input  wire flag_rf_pkg::flags_t     write0_flags,
  input  wire                          write1_en,
  input  wire [ADDR_WIDTH-1:0]         write1_addr,
  input  wire flag_rf_pkg::flags_t     write1_flags,
  input  wire                          write2_en,
  input  wire [ADDR_WIDTH-1:0]         write2_addr,
  input  wire flag_rf_pkg::flags_t     write2_flags,

  input  wire                          alloc_en,
  input  wire [ADDR_WIDTH-1:0]         alloc_addr,

  input  wire                          read_en,
  input  wire [ADDR_WIDTH-1:0]         read_addr,
  output flag_rf_pkg::entry_t          read_data,
  output logic                         read_valid,
  output logic                         read_forward,

  input  wire                          retire_en,
  input  wire [ADDR_WIDTH-1:0]         retire_addr,
  output flag_rf_pkg::flags_t          retire_flags,

  output logic                         sweep_busy
);

  // bank write bus, shared by storage and forwarding
  logic [2:0]            bank_wen;
  logic [ADDR_WIDTH-1:0] bank_waddr0;
  logic [ADDR_WIDTH-1:0] bank_waddr1;
  logic [ADDR_WIDTH-1:0] bank_waddr2;
  flag_rf_pkg::entry_t   bank_wdata0;
  flag_rf_pkg::entry_t   bank_wdata1;
  flag_rf_pkg::entry_t   bank_wdata2;
  logic                  bank_alloc_en;
  logic [ADDR_WIDTH-1:0] bank_alloc_addr;

  logic [ADDR_WIDTH-1:0] held_addr;
  flag_rf_pkg::entry_t   held_entry;

  flag_write_stage #(
    .REG_COUNT  (REG_COUNT),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_flag_write_stage (
    .clk (clk), .rst (rst),
    .write0_en (write0_en), .write0_addr (write0_addr), .write0_flags (write0_flags),
    .write1_en (write1_en), .write1_addr (write1_addr), .write1_flags (write1_flags),
    .write2_en (write2_en), .write2_addr (write2_addr), .write2_flags (write2_flags),
    .alloc_en (alloc_en), .alloc_addr (alloc_addr),
    .bank_wen (bank_wen),
    .bank_waddr0 (bank_waddr0), .bank_waddr1 (bank_waddr1), .bank_waddr2 (bank_waddr2),
    .bank_wdata0 (bank_wdata0), .bank_wdata1 (bank_wdata1), .bank_wdata2 (bank_wdata2),
    .bank_alloc_en (bank_alloc_en), .bank_alloc_addr (bank_alloc_addr),
    .sweep_busy (sweep_busy)
  );

  flag_bank #(
    .REG_COUNT  (REG_COUNT),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_flag_bank (
    .clk (clk), .rst (rst),
    .bank_wen (bank_wen),
    .bank_waddr0 (bank_waddr0), .bank_waddr1 (bank_waddr1), .bank_waddr2 (bank_waddr2),
    .bank_wdata0 (bank_wdata0), .bank_wdata1 (bank_wdata1), .bank_wdata2 (bank_wdata2),
    .bank_alloc_en (bank_alloc_en), .bank_alloc_addr (bank_alloc_addr),
    .held_addr (held_addr), .held_entry (held_entry),
    .retire_en (retire_en), .retire_addr (retire_addr), .retire_flags (retire_flags)
  );

  flag_read_bypass #(
    .REG_COUNT  (REG_COUNT),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_flag_read_bypass (
    .clk (clk), .rst (rst),
    .read_en (read_en), .read_addr (read_addr),
    .held_addr (held_addr), .held_entry (held_entry),
    .bank_wen (bank_wen),
    .bank_waddr0 (bank_waddr0), .bank_waddr1 (bank_waddr1), .bank_waddr2 (bank_waddr2),
    .bank_wdata0 (bank_wdata0), .bank_wdata1 (bank_wdata1), .bank_wdata2 (bank_wdata2),
    .bank_alloc_en (bank_alloc_en), .bank_alloc_addr (bank_alloc_addr),
    .read_data (read_data), .read_valid (read_valid), .read_forward (read_forward)
  );

endmodule

`default_nettype wire

// ==== sim/flag_regfile_properties.sv ====
// concurrent assertions on read timing, forwarding and the reset sweep
`timescale 1ns/1ns
`default_nettype none

module flag_regfile_properties (
  input wire clk,
  input wire rst,
  input wire read_en,
  input wire read_valid,
  input wire read_forward,
  input wire sweep_busy
);

  // any read strobe since reset
  logic read_seen;

  // failed assertions so far
  int assert_failures = 0;

  always_ff @(posedge clk)
  begin
    if (rst)
      read_seen <= 1'b0;
    else if (read_en)
      read_seen <= 1'b1;
  end

  valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (read_valid && !read_en) |=> !read_valid)
  else
  begin
    $error("read_valid held for two cycles without read_en");
    assert_failures++;
  end

  forward_after_read: assert property (@(posedge clk) disable iff (rst)
    read_forward |-> (read_valid || read_seen))
  else
  begin
    $error("read_forward raised before any read strobe");
    assert_failures++;
  end

  sweep_once: assert property (@(posedge clk) disable iff (rst)
    !sweep_busy |=> !sweep_busy)
  else
  begin
    $error("sweep_busy rose again after the sweep ended");
    assert_failures++;
  end

endmodule

`default_nettype wire

// ==== sim/flag_regfile_checker.sv ====
// reference model of the entries, result comparison and per-test reporting
`timescale 1ns/1ns
`default_nettype none

module flag_regfile_checker #(
  parameter int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT,
  parameter int ADDR_WIDTH = $clog2(REG_COUNT)
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      write0_en, write1_en, write2_en,
  input  wire                      alloc_en, read_en, retire_en,
  input  wire [ADDR_WIDTH-1:0]     write0_addr, write1_addr, write2_addr,
  input  wire [ADDR_WIDTH-1:0]     alloc_addr, read_addr, retire_addr,
  input  wire flag_rf_pkg::flags_t write0_flags, write1_flags, write2_flags,
  input  wire flag_rf_pkg::entry_t read_data,
  input  wire                      read_valid, read_forward, sweep_busy,
  input  wire flag_rf_pkg::flags_t retire_flags,
  input  int                       test_id,
  input  wire                      fwd_expect,
  input  wire                      run_done,
  output int                       error_count,
  output logic                     report_done
);

  flag_rf_pkg::entry_t model [REG_COUNT];

  logic [ADDR_WIDTH-1:0] held_m;
  logic [ADDR_WIDTH-1:0] retire_m;
  logic                  valid_m;
  logic                  seen_m;
  int busy_cycles = 0;
  int cur_test = 0;
  int test_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;
  flag_rf_pkg::entry_t exp_data;
  logic                exp_fwd;

  initial
  begin
    error_count = 0;
    report_done = 1'b0;
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: test %0d %s", $time, cur_test, msg);
    error_count++;
    test_errs++;
  endtask

  task automatic close_test();
    if (cur_test != 0)
    begin
      tests_run++;
      if (test_errs != 0)
        tests_failed++;
      $display("test %0d: %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "FAILED",
               test_errs);
    end
  endtask

  // allocate is checked first, then write2, write1 and write0
  task automatic predict_read();
    exp_fwd  = 1'b1;
    if (alloc_en && alloc_addr == held_m)
      exp_data = '1;
    else if (write2_en && write2_addr == held_m)
      exp_data = {1'b0, write2_flags};
    else if (write1_en && write1_addr == held_m)
      exp_data = {1'b0, write1_flags};
    else if (write0_en && write0_addr == held_m)
      exp_data = {1'b0, write0_flags};
    else
    begin
      exp_data = model[held_m];
      exp_fwd  = 1'b0;
    end
    if (!seen_m)
    begin
      exp_data = '0;
      exp_fwd  = 1'b0;
    end
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < REG_COUNT; i++)
        model[i] = '0;
      held_m      = '0;
      retire_m    = '0;
      valid_m     = 1'b0;
      seen_m      = 1'b0;
      busy_cycles = 0;
    end
    else
    begin
      if (sweep_busy)
        busy_cycles++;
      else
      begin
        if (busy_cycles >= 0 && busy_cycles != REG_COUNT)
          report_error($sformatf("sweep lasted %0d cycles, expected %0d",
                                 busy_cycles, REG_COUNT));
        busy_cycles = -1;
        if (test_id != cur_test)
        begin
          close_test();
          cur_test  = test_id;
          test_errs = 0;
        end
        // ----------------------------------------
        // compare against the model
        // ----------------------------------------
        predict_read();
        if (read_valid !== valid_m)
          report_error($sformatf("read_valid %b, expected %b", read_valid, valid_m));
        if (read_data !== exp_data)
          report_error($sformatf("read_data %h, expected %h", read_data, exp_data));
        if (read_forward !== exp_fwd)
          report_error($sformatf("read_forward %b, expected %b", read_forward, exp_fwd));
        if (read_forward !== fwd_expect)
          report_error($sformatf("read_forward %b, table marks %b", read_forward,
                                 fwd_expect));
        if (retire_flags !== model[retire_m][flag_rf_pkg::FLAG_WIDTH-1:0])
          report_error($sformatf("retire_flags %h, expected %h", retire_flags,
                                 model[retire_m][flag_rf_pkg::FLAG_WIDTH-1:0]));
        // update in ascending priority so the winner lands last
        if (write0_en)
          model[write0_addr] = {1'b0, write0_flags};
        if (write1_en)
          model[write1_addr] = {1'b0, write1_flags};
        if (write2_en)
          model[write2_addr] = {1'b0, write2_flags};
        if (alloc_en)
          model[alloc_addr] = '1;
      end
      valid_m = read_en;
      if (read_en)
      begin
        held_m = read_addr;
        seen_m = 1'b1;
      end
      if (retire_en)
        retire_m = retire_addr;
      if (run_done && !report_done)
      begin
        close_test();
        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        report_done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/flag_regfile_tb.sv ====
// testbench top: clock, reset, stimulus table, watchdog and final result
`timescale 1ns/1ns
`default_nettype none

module flag_regfile_tb;

  localparam int REG_COUNT  = flag_rf_pkg::DEFAULT_REG_COUNT;
  localparam int ADDR_WIDTH = $clog2(REG_COUNT);
  localparam int CLK_PERIOD = 4;
  localparam int MAX_ROWS   = 32;

  logic clk;
  logic rst;
  logic write0_en, write1_en, write2_en, alloc_en, read_en, retire_en;
  logic [ADDR_WIDTH-1:0] write0_addr, write1_addr, write2_addr;
  logic [ADDR_WIDTH-1:0] alloc_addr, read_addr, retire_addr;
  flag_rf_pkg::flags_t write0_flags, write1_flags, write2_flags;
  flag_rf_pkg::entry_t read_data;
  flag_rf_pkg::flags_t retire_flags;
  logic read_valid, read_forward, sweep_busy;

  int   test_id;
  logic fwd_expect;
  logic run_done;
  int   error_count;
  logic report_done;
  int   seed;

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  // enable bits are {retire, read, alloc, write2, write1, write0}
  int                    row_test  [MAX_ROWS];
  logic [5:0]            row_en    [MAX_ROWS];
  logic [ADDR_WIDTH-1:0] row_addr  [MAX_ROWS][6];
  flag_rf_pkg::flags_t   row_flags [MAX_ROWS][3];
  logic                  row_fwd   [MAX_ROWS];
  int                    row_count = 0;

  flag_regfile #(.REG_COUNT(REG_COUNT), .ADDR_WIDTH(ADDR_WIDTH)) i_flag_regfile (.*);

  flag_regfile_checker #(
    .REG_COUNT(REG_COUNT), .ADDR_WIDTH(ADDR_WIDTH)
  ) i_flag_regfile_checker (.*);

  bind flag_regfile flag_regfile_properties i_flag_regfile_properties (
    .clk(clk), .rst(rst), .read_en(read_en), .read_valid(read_valid),
    .read_forward(read_forward), .sweep_busy(sweep_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic flag_rf_pkg::flags_t rand_flags();
    logic [31:0] r;
    r = $random(seed);
    return r[flag_rf_pkg::FLAG_WIDTH-1:0];
  endfunction

  task automatic add_row(input int t, input logic [5:0] en,
                         input logic [ADDR_WIDTH-1:0] a0, a1, a2,
                         input flag_rf_pkg::flags_t f0, f1, f2,
                         input logic [ADDR_WIDTH-1:0] aa, ra, ta, input logic fwd);
    row_test[row_count]  = t;
    row_en[row_count]    = en;
    row_addr[row_count]  = '{a0, a1, a2, aa, ra, ta};
    row_flags[row_count] = '{f0, f1, f2};
    row_fwd[row_count]   = fwd;
    row_count++;
  endtask

  task automatic build_table();
    // zero after sweep
    add_row(1, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 5, 0, 0);
    add_row(1, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 17, 0, 0);
    add_row(1, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 63, 0, 0);
    add_row(1, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // write then read
    add_row(2, 6'b000001, 10, 0, 0, rand_flags(), 0, 0, 0, 0, 0, 0);
    add_row(2, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(2, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 10, 0, 0);
    add_row(2, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // allocate, read, retire, then write clears pending
    add_row(3, 6'b001000, 0, 0, 0, 0, 0, 0, 20, 0, 0, 0);
    add_row(3, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 20, 0, 0);
    add_row(3, 6'b100000, 0, 0, 0, 0, 0, 0, 0, 0, 20, 0);
    add_row(3, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, 6'b000010, 0, 20, 0, 0, rand_flags(), 0, 0, 0, 0, 1);
    add_row(3, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 20, 0, 0);
    // forward to the held address and none for another address
    add_row(4, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 30, 0, 0);
    add_row(4, 6'b000100, 0, 0, 30, 0, 0, rand_flags(), 0, 0, 0, 1);
    add_row(4, 6'b000001, 31, 0, 0, rand_flags(), 0, 0, 0, 0, 0, 0);
    // port priority
    add_row(5, 6'b010000, 0, 0, 0, 0, 0, 0, 0, 40, 0, 0);
    add_row(5, 6'b000111, 40, 40, 40, rand_flags(), rand_flags(), rand_flags(), 0, 0, 0, 1);
    add_row(5, 6'b001011, 40, 40, 0, rand_flags(), rand_flags(), 0, 40, 0, 0, 1);
    add_row(5, 6'b000011, 40, 40, 0, rand_flags(), rand_flags(), 0, 0, 0, 0, 1);
    add_row(5, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // retire with a same-cycle write
    add_row(6, 6'b100001, 45, 0, 0, rand_flags(), 0, 0, 0, 0, 45, 0);
    add_row(6, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(6, 6'b000000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic apply_row(input int i);
    {retire_en, read_en, alloc_en, write2_en, write1_en, write0_en} = row_en[i];
    write0_addr  = row_addr[i][0];
    write1_addr  = row_addr[i][1];
    write2_addr  = row_addr[i][2];
    alloc_addr   = row_addr[i][3];
    read_addr    = row_addr[i][4];
    retire_addr  = row_addr[i][5];
    write0_flags = row_flags[i][0];
    write1_flags = row_flags[i][1];
    write2_flags = row_flags[i][2];
    test_id      = row_test[i];
    fwd_expect   = row_fwd[i];
  endtask

  initial
  begin
    seed       = 30;
    rst        = 1'b1;
    test_id    = 0;
    fwd_expect = 1'b0;
    run_done   = 1'b0;
    build_table();
    apply_row(row_count - 1);
    test_id = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (sweep_busy)
      @(negedge clk);
    for (int i = 0; i < row_count; i++)
    begin
      apply_row(i);
      @(negedge clk);
    end
    apply_row(row_count - 1);
    run_done = 1'b1;
    wait (report_done);
    if (error_count == 0 && i_flag_regfile.i_flag_regfile_properties.assert_failures == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial
  begin
    wait (row_count > 0);
    #((row_count + REG_COUNT + 20) * CLK_PERIOD);
    $display("run timed out before the table finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/flag_rf_pkg.sv
design/flag_write_stage.sv
design/flag_bank.sv
design/flag_read_bypass.sv
design/flag_regfile.sv
sim/flag_regfile_properties.sv
sim/flag_regfile_checker.sv
sim/flag_regfile_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := flag_regfile_tb
FILELIST  := compile.f
PASS_MSG  := Simulation completed successfully

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
